/* rtl/rv_regs_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RISC-V register file types
// Widths, port counts and write structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rv_regs_pkg;

    // Core dimensions
    localparam int XLEN        = 32;
    localparam int NB_ALU_UNIT = 2;
    localparam int REGNUM      = 32;
    localparam int ADDR_W      = $clog2(REGNUM);
    localparam int NB_STRB     = XLEN / 8;

    // Port counts seen by the bank and the read side
    localparam int NB_WR = 2 + NB_ALU_UNIT;
    localparam int NB_RD = 3 + 2 * NB_ALU_UNIT;

    // Write port order, lowest priority last
    localparam int WR_CTRL      = 0;
    localparam int WR_CSR       = 1;
    localparam int WR_PROC_BASE = 2;

    // Read port order, units take two slots each
    localparam int RD_CTRL_RS1  = 0;
    localparam int RD_CTRL_RS2  = 1;
    localparam int RD_CSR_RS1   = 2;
    localparam int RD_PROC_BASE = 3;

    typedef logic [ADDR_W-1:0]  reg_addr_t;
    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [NB_STRB-1:0] strb_t;

    // Controller and CSR manager write
    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        xlen_t     val;
    } full_wr_t;

    // Processing unit write with byte lanes
    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        xlen_t     val;
        strb_t     strb;
    } proc_wr_t;

    // One resolved write into the bank
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        xlen_t     data;
        strb_t     strb;
    } wr_port_t;

endpackage

`default_nettype wire

/* rtl/rv_write_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file write arbiter
// Applies writer priority and maps all writers onto strobed ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module rv_write_arbiter (
    input  wire rv_regs_pkg::full_wr_t ctrl_wr,
    input  wire rv_regs_pkg::full_wr_t csr_wr,
    input  wire rv_regs_pkg::proc_wr_t proc_wr  [rv_regs_pkg::NB_ALU_UNIT],
    output      rv_regs_pkg::wr_port_t wr_ports [rv_regs_pkg::NB_WR]
);

    import rv_regs_pkg::*;

    logic                   ctrl_live;
    logic                   csr_live;
    logic                   csr_vs_ctrl;
    logic [NB_ALU_UNIT-1:0] proc_live;

    // Full-width write seen as a port with every lane strobed
    function automatic wr_port_t widen(input full_wr_t w, input logic en);
        wr_port_t p;
        p.en   = en;
        p.addr = w.addr;
        p.data = w.val;
        p.strb = '1;
        return p;
    endfunction

    // Controller only loses on x0
    assign ctrl_live = ctrl_wr.wr && (ctrl_wr.addr != '0);

    assign csr_vs_ctrl = ctrl_wr.wr && (ctrl_wr.addr == csr_wr.addr);
    assign csr_live    = csr_wr.wr && (csr_wr.addr != '0) && !csr_vs_ctrl;

    // Units yield to both full-width writers
    always_comb begin
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            proc_live[u] = proc_wr[u].wr && (proc_wr[u].addr != '0);
            if (ctrl_wr.wr && (ctrl_wr.addr == proc_wr[u].addr)) begin
                proc_live[u] = 1'b0;
            end
            if (csr_wr.wr && (csr_wr.addr == proc_wr[u].addr)) begin
                proc_live[u] = 1'b0;
            end
        end
    end

    always_comb begin
        wr_ports[WR_CTRL] = widen(ctrl_wr, ctrl_live);
        wr_ports[WR_CSR]  = widen(csr_wr, csr_live);
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            wr_ports[WR_PROC_BASE+u].en   = proc_live[u];
            wr_ports[WR_PROC_BASE+u].addr = proc_wr[u].addr;
            wr_ports[WR_PROC_BASE+u].data = proc_wr[u].val;
            wr_ports[WR_PROC_BASE+u].strb = proc_wr[u].strb;
        end
    end

    // The bank relies on x0 never being enabled here
    always_comb begin
        for (int p = 0; p < NB_WR; p++) begin
            a_no_x0_write: assert final (!(wr_ports[p].en && wr_ports[p].addr == '0))
                else $error("write port %0d enabled on x0", p);
        end
    end

    // Bank merges unit lanes, so units must never overlap a full-width write
    always_comb begin
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            a_unit_yields: assert final (!(wr_ports[WR_PROC_BASE+u].en &&
                ((wr_ports[WR_CTRL].en &&
                  wr_ports[WR_CTRL].addr == wr_ports[WR_PROC_BASE+u].addr) ||
                 (wr_ports[WR_CSR].en &&
                  wr_ports[WR_CSR].addr == wr_ports[WR_PROC_BASE+u].addr))))
                else $error("unit %0d write collides with a full-width write", u);
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_register_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register bank, x1 to x31 with byte-strobed writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module rv_register_bank (
    input  wire                        aclk,
    input  wire                        aresetn,
    input  wire                        srst,
    input  wire rv_regs_pkg::wr_port_t wr_ports [rv_regs_pkg::NB_WR],
    output wire rv_regs_pkg::xlen_t    regs     [rv_regs_pkg::REGNUM]
);

    import rv_regs_pkg::*;

    // x0 has no storage
    assign regs[0] = '0;

    for (genvar r = 1; r < REGNUM; r++) begin : g_reg

        xlen_t q;
        xlen_t d;

        // Later ports override earlier ones, lane by lane
        always_comb begin
            d = q;
            for (int p = 0; p < NB_WR; p++) begin
                if (wr_ports[p].en && (wr_ports[p].addr == reg_addr_t'(r))) begin
                    for (int b = 0; b < NB_STRB; b++) begin
                        if (wr_ports[p].strb[b]) begin
                            d[b*8 +: 8] = wr_ports[p].data[b*8 +: 8];
                        end
                    end
                end
            end
        end

        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) begin
                q <= '0;
            end else if (srst) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end

        assign regs[r] = q;

    end

    a_x0_zero: assert property (
        @(posedge aclk) disable iff (!aresetn) regs[0] == '0
    ) else $error("x0 reads non-zero");

endmodule

`default_nettype wire

/* rtl/rv_read_ports.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file read ports
// One register mux per port, optionally registered
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module rv_read_ports #(
    parameter int SYNC_READ = 0
) (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire                         srst,
    input  wire rv_regs_pkg::xlen_t     regs    [rv_regs_pkg::REGNUM],
    input  wire rv_regs_pkg::reg_addr_t rd_addr [rv_regs_pkg::NB_RD],
    output      rv_regs_pkg::xlen_t     rd_val  [rv_regs_pkg::NB_RD]
);

    import rv_regs_pkg::*;

    xlen_t sel [NB_RD];

    // 32-to-1 select per port
    always_comb begin
        for (int p = 0; p < NB_RD; p++) begin
            sel[p] = regs[rd_addr[p]];
        end
    end

    if (SYNC_READ != 0) begin : g_sync

        // Sampled on the rising edge, so a same-cycle write shows one cycle later
        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) begin
                for (int p = 0; p < NB_RD; p++) begin
                    rd_val[p] <= '0;
                end
            end else if (srst) begin
                for (int p = 0; p < NB_RD; p++) begin
                    rd_val[p] <= '0;
                end
            end else begin
                for (int p = 0; p < NB_RD; p++) begin
                    rd_val[p] <= sel[p];
                end
            end
        end

    end else begin : g_comb

        assign rd_val = sel;

    end

    // Unknown index would spread X through the whole mux
    for (genvar p = 0; p < NB_RD; p++) begin : g_chk
        a_addr_known: assert property (
            @(posedge aclk) disable iff (!aresetn) !$isunknown(rd_addr[p])
        ) else $error("read port %0d address unknown", p);
    end

endmodule

`default_nettype wire

/* rtl/rv_regfile_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RISC-V general-purpose register file
// Arbitrated writes from three client kinds, shared read ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module rv_regfile_top #(
    parameter int SYNC_READ = 0
) (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire                         srst,
    // Write side
    input  wire rv_regs_pkg::full_wr_t  ctrl_wr,
    input  wire rv_regs_pkg::full_wr_t  csr_wr,
    input  wire rv_regs_pkg::proc_wr_t  proc_wr       [rv_regs_pkg::NB_ALU_UNIT],
    // Read addresses
    input  wire rv_regs_pkg::reg_addr_t ctrl_rs1_addr,
    input  wire rv_regs_pkg::reg_addr_t ctrl_rs2_addr,
    input  wire rv_regs_pkg::reg_addr_t csr_rs1_addr,
    input  wire rv_regs_pkg::reg_addr_t proc_rs1_addr [rv_regs_pkg::NB_ALU_UNIT],
    input  wire rv_regs_pkg::reg_addr_t proc_rs2_addr [rv_regs_pkg::NB_ALU_UNIT],
    // Read values
    output      rv_regs_pkg::xlen_t     ctrl_rs1_val,
    output      rv_regs_pkg::xlen_t     ctrl_rs2_val,
    output      rv_regs_pkg::xlen_t     csr_rs1_val,
    output      rv_regs_pkg::xlen_t     proc_rs1_val  [rv_regs_pkg::NB_ALU_UNIT],
    output      rv_regs_pkg::xlen_t     proc_rs2_val  [rv_regs_pkg::NB_ALU_UNIT]
);

    import rv_regs_pkg::*;

    wr_port_t  wr_ports [NB_WR];
    xlen_t     regs     [REGNUM];
    reg_addr_t rd_addr  [NB_RD];
    xlen_t     rd_val   [NB_RD];

    // Flatten read requests into the port order of the package
    assign rd_addr[RD_CTRL_RS1] = ctrl_rs1_addr;
    assign rd_addr[RD_CTRL_RS2] = ctrl_rs2_addr;
    assign rd_addr[RD_CSR_RS1]  = csr_rs1_addr;

    assign ctrl_rs1_val = rd_val[RD_CTRL_RS1];
    assign ctrl_rs2_val = rd_val[RD_CTRL_RS2];
    assign csr_rs1_val  = rd_val[RD_CSR_RS1];

    for (genvar u = 0; u < NB_ALU_UNIT; u++) begin : g_proc
        // rs1 then rs2 for each unit
        assign rd_addr[RD_PROC_BASE + 2*u]     = proc_rs1_addr[u];
        assign rd_addr[RD_PROC_BASE + 2*u + 1] = proc_rs2_addr[u];
        assign proc_rs1_val[u] = rd_val[RD_PROC_BASE + 2*u];
        assign proc_rs2_val[u] = rd_val[RD_PROC_BASE + 2*u + 1];
    end

    rv_write_arbiter i_rv_write_arbiter (
        .ctrl_wr  (ctrl_wr),
        .csr_wr   (csr_wr),
        .proc_wr  (proc_wr),
        .wr_ports (wr_ports)
    );

    rv_register_bank i_rv_register_bank (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .wr_ports (wr_ports),
        .regs     (regs)
    );

    rv_read_ports #(
        .SYNC_READ (SYNC_READ)
    ) i_rv_read_ports (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .regs    (regs),
        .rd_addr (rd_addr),
        .rd_val  (rd_val)
    );

endmodule

`default_nettype wire

/* verif/rv_regfile_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file testbench
// Reference model with directed and random traffic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module rv_regfile_tb;

    import rv_regs_pkg::*;

    localparam int CLK_HALF      = 10;
    localparam int RESET_CYCLES  = 4;
    localparam int WRITER_ROUNDS = 8;
    localparam int RAND_CYCLES   = 2000;
    localparam int MAX_CLEARS    = 20;
    // Initial sweep, writer rounds of five cycles, x0 case, three priority cases
    localparam int DIRECTED_CYCLES = REGNUM + WRITER_ROUNDS * 5 + 2 + 6;
    // Each clear costs its own cycle plus a full sweep, one extra clear at the end
    localparam int TEST_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES
                               + (MAX_CLEARS + 1) * (REGNUM + 1);
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

    logic      aclk;
    logic      aresetn;
    logic      srst;
    full_wr_t  ctrl_wr;
    full_wr_t  csr_wr;
    proc_wr_t  proc_wr       [NB_ALU_UNIT];
    reg_addr_t ctrl_rs1_addr;
    reg_addr_t ctrl_rs2_addr;
    reg_addr_t csr_rs1_addr;
    reg_addr_t proc_rs1_addr [NB_ALU_UNIT];
    reg_addr_t proc_rs2_addr [NB_ALU_UNIT];
    xlen_t     ctrl_rs1_val;
    xlen_t     ctrl_rs2_val;
    xlen_t     csr_rs1_val;
    xlen_t     proc_rs1_val  [NB_ALU_UNIT];
    xlen_t     proc_rs2_val  [NB_ALU_UNIT];

    xlen_t       model [REGNUM];
    logic [31:0] rng_state = 32'd16;
    int unsigned cycle_cnt = 0;
    logic        failed    = 1'b0;

    rv_regfile_top #(
        .SYNC_READ (0)
    ) i_rv_regfile_top (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .srst          (srst),
        .ctrl_wr       (ctrl_wr),
        .csr_wr        (csr_wr),
        .proc_wr       (proc_wr),
        .ctrl_rs1_addr (ctrl_rs1_addr),
        .ctrl_rs2_addr (ctrl_rs2_addr),
        .csr_rs1_addr  (csr_rs1_addr),
        .proc_rs1_addr (proc_rs1_addr),
        .proc_rs2_addr (proc_rs2_addr),
        .ctrl_rs1_val  (ctrl_rs1_val),
        .ctrl_rs2_val  (ctrl_rs2_val),
        .csr_rs1_val   (csr_rs1_val),
        .proc_rs1_val  (proc_rs1_val),
        .proc_rs2_val  (proc_rs2_val)
    );

    initial aclk = 1'b0;
    always #CLK_HALF aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Mostly low registers so that writers collide often
    function automatic reg_addr_t rand_addr();
        logic [31:0] v;
        v = next_random();
        return v[31] ? reg_addr_t'(v[4:0]) : reg_addr_t'(v[2:0]);
    endfunction

    // Next value of register r after one cycle of writes
    function automatic xlen_t model_write(input xlen_t old, input int r, input full_wr_t c,
                                          input full_wr_t s, input proc_wr_t p [NB_ALU_UNIT]);
        xlen_t nxt;
        nxt = old;
        if (r == 0) return '0;
        if (c.wr && c.addr == r) return c.val;
        if (s.wr && s.addr == r) return s.val;
        // Ascending unit order, so the higher index keeps shared lanes
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            if (p[u].wr && p[u].addr == r) begin
                for (int b = 0; b < NB_STRB; b++) begin
                    if (p[u].strb[b]) nxt[b*8 +: 8] = p[u].val[b*8 +: 8];
                end
            end
        end
        return nxt;
    endfunction

    task automatic abort_run();
        failed = 1'b1;
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("FAIL time=%0t %s expected=%08h actual=%08h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_zero(input string name, input xlen_t act);
        if (act !== '0) begin
            $display("FAIL time=%0t %s expected=00000000 actual=%08h", $time, name, act);
            abort_run();
        end
    endtask

    task automatic idle_writes();
        ctrl_wr <= '0;
        csr_wr  <= '0;
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            proc_wr[u] <= '0;
        end
    endtask

    task automatic read_all(input reg_addr_t a);
        ctrl_rs1_addr <= a;
        ctrl_rs2_addr <= a;
        csr_rs1_addr  <= a;
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            proc_rs1_addr[u] <= a;
            proc_rs2_addr[u] <= a;
        end
    endtask

    // Every port visits every register, each port offset by one
    task automatic sweep_zero();
        for (int i = 0; i < REGNUM; i++) begin
            ctrl_rs1_addr <= reg_addr_t'(i);
            ctrl_rs2_addr <= reg_addr_t'(i + 1);
            csr_rs1_addr  <= reg_addr_t'(i + 2);
            for (int u = 0; u < NB_ALU_UNIT; u++) begin
                proc_rs1_addr[u] <= reg_addr_t'(i + 3 + 2*u);
                proc_rs2_addr[u] <= reg_addr_t'(i + 4 + 2*u);
            end
            @(negedge aclk);
            check_zero("ctrl_rs1_val", ctrl_rs1_val);
            check_zero("ctrl_rs2_val", ctrl_rs2_val);
            check_zero("csr_rs1_val", csr_rs1_val);
            for (int u = 0; u < NB_ALU_UNIT; u++) begin
                check_zero($sformatf("proc_rs1_val[%0d]", u), proc_rs1_val[u]);
                check_zero($sformatf("proc_rs2_val[%0d]", u), proc_rs2_val[u]);
            end
            @(posedge aclk);
        end
    endtask

    task automatic drive_random();
        logic [31:0] v;
        v = next_random();
        ctrl_wr <= '{v[1:0] == 2'd0, rand_addr(), next_random()};
        csr_wr  <= '{v[3:2] == 2'd0, rand_addr(), next_random()};
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            proc_wr[u] <= '{v[4+u], rand_addr(), next_random(), strb_t'(next_random())};
        end
        ctrl_rs1_addr <= reg_addr_t'(next_random());
        ctrl_rs2_addr <= reg_addr_t'(next_random());
        csr_rs1_addr  <= reg_addr_t'(next_random());
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            proc_rs1_addr[u] <= reg_addr_t'(next_random());
            proc_rs2_addr[u] <= reg_addr_t'(next_random());
        end
    endtask

    always @(posedge aclk) begin
        for (int r = 0; r < REGNUM; r++) begin
            if (!aresetn || srst) begin
                model[r] = '0;
            end else begin
                model[r] = model_write(model[r], r, ctrl_wr, csr_wr, proc_wr);
            end
        end
    end

    // Reads show the state stored at the last edge
    always @(negedge aclk) begin
        if (aresetn) begin
            check_val("ctrl_rs1_val", model[ctrl_rs1_addr], ctrl_rs1_val);
            check_val("ctrl_rs2_val", model[ctrl_rs2_addr], ctrl_rs2_val);
            check_val("csr_rs1_val", model[csr_rs1_addr], csr_rs1_val);
            for (int u = 0; u < NB_ALU_UNIT; u++) begin
                check_val($sformatf("proc_rs1_val[%0d]", u), model[proc_rs1_addr[u]],
                          proc_rs1_val[u]);
                check_val($sformatf("proc_rs2_val[%0d]", u), model[proc_rs2_addr[u]],
                          proc_rs2_val[u]);
            end
        end
    end

    always @(posedge aclk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] v;
        reg_addr_t   tgt;
        xlen_t       cv;
        xlen_t       sv;
        xlen_t       av;
        xlen_t       bv;
        int          clears;
        clears  = 0;
        aresetn = 1'b0;
        srst    = 1'b0;
        ctrl_wr = '0;
        csr_wr  = '0;
        ctrl_rs1_addr = '0;
        ctrl_rs2_addr = '0;
        csr_rs1_addr  = '0;
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            proc_wr[u]       = '0;
            proc_rs1_addr[u] = '0;
            proc_rs2_addr[u] = '0;
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
        sweep_zero();

        // One writer per cycle, reads on the target see old then new value
        for (int k = 0; k < WRITER_ROUNDS; k++) begin
            tgt = reg_addr_t'(1 + next_random() % (REGNUM - 1));
            read_all(tgt);
            for (int w = 0; w < 2 + NB_ALU_UNIT; w++) begin
                idle_writes();
                if (w == 0) ctrl_wr <= '{1'b1, tgt, next_random()};
                else if (w == 1) csr_wr <= '{1'b1, tgt, next_random()};
                else proc_wr[w-2] <= '{1'b1, tgt, next_random(), strb_t'(next_random())};
                @(posedge aclk);
            end
            idle_writes();
            @(posedge aclk);
        end

        // x0 targeted by every writer
        read_all('0);
        ctrl_wr <= '{1'b1, reg_addr_t'(0), next_random()};
        csr_wr  <= '{1'b1, reg_addr_t'(0), next_random()};
        for (int u = 0; u < NB_ALU_UNIT; u++) begin
            proc_wr[u] <= '{1'b1, reg_addr_t'(0), next_random(), '1};
        end
        @(posedge aclk);
        idle_writes();
        @(negedge aclk);
        check_zero("ctrl_rs1_val", ctrl_rs1_val);
        @(posedge aclk);

        // Priority on one register
        tgt = reg_addr_t'(1 + next_random() % (REGNUM - 1));
        cv  = next_random();
        sv  = next_random();
        av  = next_random();
        bv  = next_random();
        read_all(tgt);
        ctrl_wr    <= '{1'b1, tgt, cv};
        csr_wr     <= '{1'b1, tgt, sv};
        proc_wr[0] <= '{1'b1, tgt, av, 4'b1111};
        proc_wr[1] <= '{1'b1, tgt, bv, 4'b1111};
        @(posedge aclk);
        idle_writes();
        @(negedge aclk);
        check_val("ctrl_rs1_val", cv, ctrl_rs1_val);
        @(posedge aclk);
        csr_wr     <= '{1'b1, tgt, sv};
        proc_wr[0] <= '{1'b1, tgt, av, 4'b1111};
        proc_wr[1] <= '{1'b1, tgt, bv, 4'b1111};
        @(posedge aclk);
        idle_writes();
        @(negedge aclk);
        check_val("ctrl_rs1_val", sv, ctrl_rs1_val);
        @(posedge aclk);
        // Lane 1 strobed by both units, lane 3 by none
        proc_wr[0] <= '{1'b1, tgt, av, 4'b0011};
        proc_wr[1] <= '{1'b1, tgt, bv, 4'b0110};
        @(posedge aclk);
        idle_writes();
        @(negedge aclk);
        check_val("ctrl_rs1_val", {sv[31:24], bv[23:8], av[7:0]}, ctrl_rs1_val);
        @(posedge aclk);

        for (int i = 0; i < RAND_CYCLES; i++) begin
            v = next_random();
            drive_random();
            if (v[6:0] == 7'd0 && clears < MAX_CLEARS) begin
                srst <= 1'b1;
                @(posedge aclk);
                srst <= 1'b0;
                idle_writes();
                sweep_zero();
                clears++;
            end else begin
                @(posedge aclk);
            end
        end

        drive_random();
        srst <= 1'b1;
        @(posedge aclk);
        srst <= 1'b0;
        idle_writes();
        sweep_zero();

        if (!failed) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "run ended with failed checks");
        end
    end

endmodule

`default_nettype wire

/* rv_regfile_top.f */
rtl/rv_regs_pkg.sv
rtl/rv_write_arbiter.sv
rtl/rv_register_bank.sv
rtl/rv_read_ports.sv
rtl/rv_regfile_top.sv
verif/rv_regfile_tb.sv
